// File: filelist.f
fpu_pkg.sv
fp_addsub.sv
fp_mul.sv
fp_div.sv
fpu_ctrl.sv
fpu_top.sv
tb_clock.sv
fpu_assert.sv
fpu_tb.sv

// File: fp_addsub.sv
`default_nettype none

module fp_addsub (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  fpu_pkg::fpu_op_t op,
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  output logic [31:0]      q
);

  localparam int SIG_W   = fpu_pkg::MANT_W + 1;         // significand incl. hidden one
  localparam int EXT_W   = SIG_W + 3;                   // plus guard, round, sticky
  localparam int SE_W    = fpu_pkg::EXP_W + 2;          // signed exponent for range checks
  localparam int LZ_W    = $clog2(EXT_W + 2);
  localparam int EXP_MAX = (1 << fpu_pkg::EXP_W) - 1;

  logic [31:0] a_r;
  logic [31:0] b_r;
  logic        sub_r;

  logic                      sa, sb;
  logic [fpu_pkg::EXP_W-1:0] ea, eb;
  logic [SIG_W-1:0]          ma, mb;
  logic                      swap;

  logic                      s1_sl, s1_ss;      // signs of larger and smaller operand
  logic [fpu_pkg::EXP_W-1:0] s1_el, s1_ed;      // larger exponent, exponent difference
  logic [SIG_W-1:0]          s1_ml, s1_ms;

  logic [EXT_W-1:0] l_ext, s_full, s_shift, s_mask, s_al;
  logic             eff_sub;
  logic [EXT_W:0]   sum;

  logic                      s2_sign, s2_zsign;
  logic [fpu_pkg::EXP_W-1:0] s2_exp;
  logic [EXT_W:0]            s2_sum;

  logic [LZ_W-1:0]        lz;
  logic [EXT_W:0]         norm;
  logic signed [SE_W-1:0] e_norm;
  logic [31:0]            q_n;

  always_ff @(posedge clk) begin
    if (en) begin
      a_r   <= a;
      b_r   <= b;
      sub_r <= op[0];
    end
  end

  // stage one: unpack, flush subnormals, order by magnitude
  always_comb begin
    sa   = a_r[31];
    sb   = b_r[31] ^ sub_r;                       // subtract flips b
    ea   = a_r[30 -: fpu_pkg::EXP_W];
    eb   = b_r[30 -: fpu_pkg::EXP_W];
    ma   = (ea == '0) ? '0 : {1'b1, a_r[fpu_pkg::MANT_W-1:0]};
    mb   = (eb == '0) ? '0 : {1'b1, b_r[fpu_pkg::MANT_W-1:0]};
    swap = {eb, mb} > {ea, ma};
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_sl <= swap ? sb : sa;
      s1_ss <= swap ? sa : sb;
      s1_el <= swap ? eb : ea;
      s1_ed <= swap ? eb - ea : ea - eb;
      s1_ml <= swap ? mb : ma;
      s1_ms <= swap ? ma : mb;
    end
  end

  // stage two: align smaller operand, keep a sticky bit, add or subtract
  always_comb begin
    l_ext   = {s1_ml, 3'b000};
    s_full  = {s1_ms, 3'b000};
    s_shift = s_full >> s1_ed;                    // all zero for huge differences
    s_mask  = ~({EXT_W{1'b1}} << s1_ed);          // bits shifted out
    s_al    = {s_shift[EXT_W-1:1], s_shift[0] | (|(s_full & s_mask))};
    eff_sub = s1_sl ^ s1_ss;
    sum     = eff_sub ? {1'b0, l_ext} - {1'b0, s_al} : {1'b0, l_ext} + {1'b0, s_al};
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s2_sign  <= s1_sl;
      s2_zsign <= s1_sl & ~eff_sub;               // only -0 + -0 stays negative
      s2_exp   <= s1_el;
      s2_sum   <= sum;
    end
  end

  // stage three: leading-zero count, normalize, truncate, pack
  always_comb begin
    lz = LZ_W'(EXT_W + 1);
    for (int i = 0; i <= EXT_W; i++) begin
      if (s2_sum[i]) lz = LZ_W'(EXT_W - i);       // highest set bit wins
    end
    norm   = s2_sum << lz;
    e_norm = SE_W'(s2_exp) + SE_W'(1) - SE_W'(lz);  // hidden one sits one below the carry
    if (s2_sum == '0)
      q_n = {s2_zsign, 31'b0};                    // exact cancellation
    else if (e_norm >= EXP_MAX)
      q_n = {s2_sign, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MANT_W{1'b0}}};
    else if (e_norm <= 0)
      q_n = {s2_sign, 31'b0};                     // underflow flushes
    else
      q_n = {s2_sign, e_norm[fpu_pkg::EXP_W-1:0], norm[EXT_W-1 -: fpu_pkg::MANT_W]};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      q <= '0;
    else if (en)
      q <= q_n;
  end

endmodule

`default_nettype wire

// File: fp_div.sv
`default_nettype none

module fp_div (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] q
);

  localparam int SIG_W     = fpu_pkg::MANT_W + 1;
  localparam int SE_W      = fpu_pkg::EXP_W + 2;
  localparam int STEP_W    = $clog2(fpu_pkg::DIV_LATENCY);
  localparam int NORM_STEP = fpu_pkg::DIV_LATENCY - 1;   // step 0 is setup
  localparam int EXP_MAX   = (1 << fpu_pkg::EXP_W) - 1;

  logic              active;
  logic [STEP_W-1:0] step;

  logic [31:0] a_r;
  logic [31:0] b_r;

  logic [fpu_pkg::EXP_W-1:0] ea, eb;

  logic                   sign_r, zero_r;
  logic signed [SE_W-1:0] exp_r;
  logic [SIG_W:0]         rem;                    // partial remainder, below 2x divisor
  logic [SIG_W-1:0]       dvs;
  logic [SIG_W-1:0]       quot;

  logic [SIG_W:0]             rem_sub;
  logic                       rem_ge;
  logic signed [SE_W-1:0]     e_q;
  logic [fpu_pkg::MANT_W-1:0] mant;
  logic [31:0]                q_n;

  assign ea      = a_r[30 -: fpu_pkg::EXP_W];
  assign eb      = b_r[30 -: fpu_pkg::EXP_W];
  assign rem_sub = rem - {1'b0, dvs};
  assign rem_ge  = rem >= {1'b0, dvs};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active <= 1'b0;
      step   <= '0;
    end else if (!en) begin
      active <= 1'b0;                             // dropped enable ends the operation
      step   <= '0;
    end else if (!active) begin
      active <= 1'b1;
    end else if (step != STEP_W'(NORM_STEP)) begin
      step <= step + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (!active) begin
        a_r <= a;
        b_r <= b;
      end else if (step == '0) begin
        sign_r <= a_r[31] ^ b_r[31];
        zero_r <= (ea == '0);                     // flushed dividend
        exp_r  <= SE_W'(ea) - SE_W'(eb) + SE_W'(fpu_pkg::EXP_BIAS);
        rem    <= {2'b01, a_r[fpu_pkg::MANT_W-1:0]};
        dvs    <= {1'b1, b_r[fpu_pkg::MANT_W-1:0]};
        quot   <= '0;
      end else if (step != STEP_W'(NORM_STEP)) begin
        quot <= {quot[SIG_W-2:0], rem_ge};        // one restoring step
        rem  <= rem_ge ? {rem_sub[SIG_W-1:0], 1'b0} : {rem[SIG_W-1:0], 1'b0};
      end
    end
  end

  // quotient lies in (1/2, 2); when below one the next bit comes from the remainder
  always_comb begin
    if (quot[SIG_W-1]) begin
      e_q  = exp_r;
      mant = quot[fpu_pkg::MANT_W-1:0];
    end else begin
      e_q  = exp_r - SE_W'(1);
      mant = {quot[fpu_pkg::MANT_W-2:0], rem_ge};
    end
    if (zero_r || e_q <= 0)
      q_n = {sign_r, 31'b0};
    else if (e_q >= EXP_MAX)
      q_n = {sign_r, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MANT_W{1'b0}}};
    else
      q_n = {sign_r, e_q[fpu_pkg::EXP_W-1:0], mant};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      q <= '0;
    else if (en && active && step == STEP_W'(NORM_STEP))
      q <= q_n;
  end

endmodule

`default_nettype wire

// File: fp_mul.sv
`default_nettype none

module fp_mul (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] q
);

  localparam int SIG_W   = fpu_pkg::MANT_W + 1;
  localparam int SE_W    = fpu_pkg::EXP_W + 2;
  localparam int EXP_MAX = (1 << fpu_pkg::EXP_W) - 1;

  logic [31:0] a_r;
  logic [31:0] b_r;

  logic [fpu_pkg::EXP_W-1:0] ea, eb;

  logic                   s1_sign, s1_zero;
  logic signed [SE_W-1:0] s1_exp;
  logic [SIG_W-1:0]       s1_ma, s1_mb;

  logic                   s2_sign, s2_zero;
  logic signed [SE_W-1:0] s2_exp;
  logic [2*SIG_W-1:0]     s2_prod;

  logic signed [SE_W-1:0]    e_norm;
  logic [fpu_pkg::MANT_W-1:0] mant;
  logic [31:0]               q_n;

  always_ff @(posedge clk) begin
    if (en) begin
      a_r <= a;
      b_r <= b;
    end
  end

  assign ea = a_r[30 -: fpu_pkg::EXP_W];
  assign eb = b_r[30 -: fpu_pkg::EXP_W];

  // stage one: sign, exponent sum and zero detect
  // stage two: significand product
  always_ff @(posedge clk) begin
    if (en) begin
      s1_sign <= a_r[31] ^ b_r[31];
      s1_zero <= (ea == '0) || (eb == '0);        // subnormals count as zero
      s1_exp  <= SE_W'(ea) + SE_W'(eb) - SE_W'(fpu_pkg::EXP_BIAS);
      s1_ma   <= {1'b1, a_r[fpu_pkg::MANT_W-1:0]};
      s1_mb   <= {1'b1, b_r[fpu_pkg::MANT_W-1:0]};
      s2_sign <= s1_sign;
      s2_zero <= s1_zero;
      s2_exp  <= s1_exp;
      s2_prod <= s1_ma * s1_mb;
    end
  end

  // stage three: product lies in [1,4), at most one bit of normalization
  always_comb begin
    if (s2_prod[2*SIG_W-1]) begin
      e_norm = s2_exp + SE_W'(1);
      mant   = s2_prod[2*SIG_W-2 -: fpu_pkg::MANT_W];
    end else begin
      e_norm = s2_exp;
      mant   = s2_prod[2*SIG_W-3 -: fpu_pkg::MANT_W];
    end
    if (s2_zero || e_norm <= 0)
      q_n = {s2_sign, 31'b0};
    else if (e_norm >= EXP_MAX)
      q_n = {s2_sign, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MANT_W{1'b0}}};
    else
      q_n = {s2_sign, e_norm[fpu_pkg::EXP_W-1:0], mant};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      q <= '0;
    else if (en)
      q <= q_n;
  end

endmodule

`default_nettype wire

// File: fpu_assert.sv
`default_nettype none

module fpu_assert (
  input logic             clk,
  input logic             rst,
  input logic             en,
  input logic             start,
  input fpu_pkg::fpu_op_t op,
  input logic             busy,
  input logic             done,
  input logic             add_en,
  input logic             mul_en,
  input logic             div_en
);

  logic accept;

  assign accept = en && start && !busy;          // command taken at this edge

  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done was high in two consecutive cycles");

  one_unit: assert property (@(posedge clk) disable iff (rst)
    $onehot0({add_en, mul_en, div_en}))
    else $error("more than one unit enable high");

  // done is set on edge L+2 and is seen sampled one edge later
  add_latency: assert property (@(posedge clk) disable iff (rst)
    accept && !op[1] |-> ##(fpu_pkg::ADD_LATENCY + 3) done)
    else $error("adder command did not finish at its fixed latency");

  mul_latency: assert property (@(posedge clk) disable iff (rst)
    accept && op == fpu_pkg::OP_MUL |-> ##(fpu_pkg::MUL_LATENCY + 3) done)
    else $error("multiplier command did not finish at its fixed latency");

  div_latency: assert property (@(posedge clk) disable iff (rst)
    accept && op == fpu_pkg::OP_DIV |-> ##(fpu_pkg::DIV_LATENCY + 3) done)
    else $error("divider command did not finish at its fixed latency");

endmodule

bind fpu_ctrl fpu_assert assert0 (
  .clk    (clk),
  .rst    (rst),
  .en     (en),
  .start  (start),
  .op     (op),
  .busy   (busy),
  .done   (done),
  .add_en (add_en),
  .mul_en (mul_en),
  .div_en (div_en)
);

`default_nettype wire

// File: fpu_ctrl.sv
`default_nettype none

module fpu_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  logic             start,
  input  fpu_pkg::fpu_op_t op,
  input  logic [31:0]      add_q,
  input  logic [31:0]      mul_q,
  input  logic [31:0]      div_q,
  output logic             add_en,
  output logic             mul_en,
  output logic             div_en,
  output logic             busy,
  output logic             done,
  output logic [31:0]      result
);

  typedef enum logic [1:0] {
    IDLE,
    ADD_RUN,
    MUL_RUN,
    DIV_RUN
  } state_t;

  state_t state, state_n;

  logic [fpu_pkg::CNT_W-1:0] cnt, cnt_n;
  logic [fpu_pkg::CNT_W-1:0] last_cnt;            // capture cycle plus unit latency
  logic [31:0]               unit_q;
  logic                      at_end;
  logic                      done_n;
  logic [31:0]               result_n;

  // terminal count and result source of the running unit
  always_comb begin
    case (state)
      ADD_RUN: begin
        last_cnt = fpu_pkg::CNT_W'(fpu_pkg::ADD_LATENCY + 1);
        unit_q   = add_q;
      end
      MUL_RUN: begin
        last_cnt = fpu_pkg::CNT_W'(fpu_pkg::MUL_LATENCY + 1);
        unit_q   = mul_q;
      end
      DIV_RUN: begin
        last_cnt = fpu_pkg::CNT_W'(fpu_pkg::DIV_LATENCY + 1);
        unit_q   = div_q;
      end
      default: begin
        last_cnt = '0;
        unit_q   = add_q;
      end
    endcase
  end

  assign at_end = (state != IDLE) && (cnt == last_cnt);
  assign busy   = (state != IDLE);

  // enable stays low in the register cycle so the divider can go idle
  assign add_en = (state == ADD_RUN) && !at_end;
  assign mul_en = (state == MUL_RUN) && !at_end;
  assign div_en = (state == DIV_RUN) && !at_end;

  always_comb begin
    state_n  = state;
    cnt_n    = cnt;
    done_n   = 1'b0;
    result_n = result;
    if (state == IDLE) begin
      if (en && start) begin                      // starts while busy never reach here
        cnt_n = '0;
        if (!op[1])
          state_n = ADD_RUN;
        else if (op == fpu_pkg::OP_MUL)
          state_n = MUL_RUN;
        else
          state_n = DIV_RUN;
      end
    end else if (at_end) begin
      done_n   = 1'b1;
      result_n = unit_q;
      state_n  = IDLE;
    end else begin
      cnt_n = cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= IDLE;
      cnt    <= '0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      state  <= state_n;
      cnt    <= cnt_n;
      done   <= done_n;
      result <= result_n;
    end
  end

endmodule

`default_nettype wire

// File: fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  // operation code
  // bit 1 low selects the adder, bit 0 selects subtract
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_DIV = 2'b11
  } fpu_op_t;

  // single-precision field widths
  localparam int EXP_W    = 8;    // biased exponent
  localparam int MANT_W   = 23;   // stored fraction, hidden one not included
  localparam int EXP_BIAS = 127;

  // latencies in enabled cycles, counted after the input capture cycle
  localparam int ADD_LATENCY = 3;   // align, add, normalize
  localparam int MUL_LATENCY = 3;   // exponent, multiply, normalize

  // setup + one cycle per quotient bit + normalize
  localparam int DIV_LATENCY = 26;

  // controller counter, must hold DIV_LATENCY + 1
  localparam int CNT_W = 5;

endpackage

`default_nettype wire

// File: fpu_tb.sv
`default_nettype none

module fpu_tb;

  logic             clk;
  logic             rst;
  logic             en;
  logic             start;
  fpu_pkg::fpu_op_t op;
  logic [31:0]      a;
  logic [31:0]      b;
  logic             busy;
  logic             done;
  logic [31:0]      result;

  logic [31:0] rng;
  int          x, y, k;

  tb_clock clk0 (.clk(clk));

  fpu_top dut0 (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .start  (start),
    .op     (op),
    .a      (a),
    .b      (b),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_with_error($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                              name, expected, actual));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  // nonzero integer in [-lim, lim]
  function automatic int draw(input int lim);
    int v;
    rng = xorshift32(rng);
    v   = int'(rng % 32'(2 * lim));
    if (v < lim)
      return v - lim;
    return v - lim + 1;
  endfunction

  // exact IEEE bits of a small integer, zero as +0
  function automatic logic [31:0] int_to_fp(input int v);
    logic [31:0] mag;
    logic [31:0] mant;
    logic        sign;
    int          p;
    if (v == 0)
      return 32'h0;
    sign = (v < 0);
    mag  = sign ? 32'(-v) : 32'(v);
    p    = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) p = i;                          // msb position
    end
    mant = mag << (23 - p);
    return {sign, 8'(127 + p), mant[22:0]};
  endfunction

  function automatic int latency_of(input fpu_pkg::fpu_op_t o);
    case (o)
      fpu_pkg::OP_MUL: return fpu_pkg::MUL_LATENCY;
      fpu_pkg::OP_DIV: return fpu_pkg::DIV_LATENCY;
      default:         return fpu_pkg::ADD_LATENCY;
    endcase
  endfunction

  // issue one command, optionally pulse start again at cycle repulse while busy
  task automatic run_cmd(input string name, input fpu_pkg::fpu_op_t op_i,
                         input logic [31:0] a_i, input logic [31:0] b_i,
                         input logic [31:0] exp_i, input int repulse);
    int n;
    bit seen;
    int lat;
    lat   = latency_of(op_i);
    n     = 0;
    seen  = 1'b0;
    en    = 1'b1;
    start = 1'b1;
    op    = op_i;
    a     = a_i;
    b     = b_i;
    while (!seen && n < 64) begin
      @(posedge clk);
      #1;
      n++;
      start = (n == repulse) && !done;
      if (done)
        seen = 1'b1;
      else
        assert (busy) else stop_with_error({name, ": busy went low before done"});
    end
    if (!seen)
      stop_with_error({name, ": done never came within 64 cycles"});
    assert (n - 1 == lat + 2) else report_mismatch({name, " latency"}, 32'(lat + 2), 32'(n - 1));
    assert (result == exp_i) else report_mismatch(name, exp_i, result);
  endtask

  // nothing may start or finish for the given number of cycles
  task automatic expect_quiet(input string name, input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      #1;
      assert (!done) else stop_with_error({name, ": unexpected done pulse"});
      assert (!busy) else stop_with_error({name, ": unit started unexpectedly"});
    end
  endtask

  initial begin
    rst   = 1'b1;
    en    = 1'b0;
    start = 1'b0;
    op    = fpu_pkg::OP_ADD;
    a     = 32'h0;
    b     = 32'h0;
    rng   = 32'd91;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
    assert (!done && !busy) else stop_with_error("done or busy high after reset");
    assert (result == 32'h0) else report_mismatch("reset result", 32'h0, result);

    run_cmd("cancel_add", fpu_pkg::OP_ADD, int_to_fp(5), int_to_fp(-5), int_to_fp(0), 0);
    run_cmd("cancel_sub", fpu_pkg::OP_SUB, int_to_fp(7), int_to_fp(7), int_to_fp(0), 0);
    run_cmd("mixed_add", fpu_pkg::OP_ADD, int_to_fp(3), int_to_fp(-10), int_to_fp(-7), 0);
    run_cmd("neg_div", fpu_pkg::OP_DIV, int_to_fp(12), int_to_fp(-3), int_to_fp(-4), 0);

    for (int i = 0; i < 10; i++) begin            // back to back, each right after done
      x = draw(64);
      y = draw(64);
      k = draw(8);
      run_cmd($sformatf("add_%0d", i), fpu_pkg::OP_ADD, int_to_fp(x), int_to_fp(y),
              int_to_fp(x + y), 0);
      run_cmd($sformatf("sub_%0d", i), fpu_pkg::OP_SUB, int_to_fp(x), int_to_fp(y),
              int_to_fp(x - y), 0);
      run_cmd($sformatf("mul_%0d", i), fpu_pkg::OP_MUL, int_to_fp(x), int_to_fp(y),
              int_to_fp(x * y), 0);
      run_cmd($sformatf("div_%0d", i), fpu_pkg::OP_DIV, int_to_fp(y * k), int_to_fp(y),
              int_to_fp(k), 0);
    end

    // start with en low is ignored
    en    = 1'b0;
    start = 1'b1;
    op    = fpu_pkg::OP_MUL;
    a     = int_to_fp(9);
    b     = int_to_fp(9);
    expect_quiet("en_low", 4);
    start = 1'b0;

    // extra start pulses while busy give no second done
    run_cmd("busy_mul", fpu_pkg::OP_MUL, int_to_fp(-6), int_to_fp(11), int_to_fp(-66), 3);
    expect_quiet("busy_mul_after", fpu_pkg::DIV_LATENCY + 4);
    run_cmd("busy_div", fpu_pkg::OP_DIV, int_to_fp(-40), int_to_fp(-8), int_to_fp(5), 10);
    expect_quiet("busy_div_after", fpu_pkg::DIV_LATENCY + 4);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: fpu_top.sv
`default_nettype none

module fpu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  logic             start,
  input  fpu_pkg::fpu_op_t op,
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  output logic             busy,
  output logic             done,
  output logic [31:0]      result
);

  logic        add_en, mul_en, div_en;
  logic [31:0] add_q, mul_q, div_q;

  fpu_ctrl ctrl0 (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .start  (start),
    .op     (op),
    .add_q  (add_q),
    .mul_q  (mul_q),
    .div_q  (div_q),
    .add_en (add_en),
    .mul_en (mul_en),
    .div_en (div_en),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  fp_addsub addsub0 (.clk(clk), .rst(rst), .en(add_en), .op(op), .a(a), .b(b), .q(add_q));

  fp_mul mul0 (.clk(clk), .rst(rst), .en(mul_en), .a(a), .b(b), .q(mul_q));

  fp_div div0 (.clk(clk), .rst(rst), .en(div_en), .a(a), .b(b), .q(div_q));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module fpu_tb \
  -f filelist.f \
  -o fpu_sim

./obj_dir/fpu_sim | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #4 clk = ~clk;                           // period 8

endmodule

`default_nettype wire
